// ==== tb.f ====
src/mcu_pkg.sv
src/wb_if.sv
src/addr_decoder.sv
src/ram_bank.sv
src/rsp_collector.sv
src/gpio_ao.sv
src/mini_mcu_top.sv
verif/mini_mcu_sva.sv
verif/tb_mini_mcu.sv

// ==== Makefile ====
# Verilator lint, simulation and clean

TOP = tb_mini_mcu

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir -o vsim
	@out="$$(./obj_dir/vsim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== verif/tb_mini_mcu.sv ====
/*
 * testbench for mini_mcu_top: RAM, unmapped and GPIO tests against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mini_mcu;

  typedef logic [mcu_pkg::ADDR_W-1:0] adr_t;
  typedef logic [mcu_pkg::DATA_W-1:0] dat_t;
  typedef logic [mcu_pkg::SEL_W-1:0]  sel_t;
  typedef logic [mcu_pkg::GPIO_W-1:0] pin_t;

  localparam int unsigned RAM_WORDS  = mcu_pkg::DEF_NUM_BANKS * mcu_pkg::DEF_BANK_WORDS;
  localparam int unsigned RAM_OPS    = 200;
  localparam int          RSP_LIMIT  = 8;
  // about 450 transfers of 3 cycles each, three times over for waits and margin
  localparam int unsigned MAX_CYCLES = (2 * RAM_OPS + 50) * 3 * 3;

  logic clk_i;
  logic arst_n_i;
  logic wb_cyc_i;
  logic wb_stb_i;
  logic wb_we_i;
  sel_t wb_sel_i;
  adr_t wb_adr_i;
  dat_t wb_dat_i;
  dat_t wb_dat_o;
  logic wb_ack_o;
  logic wb_err_o;
  pin_t gpio_i;
  pin_t gpio_o;
  pin_t gpio_oe_o;
  pin_t gpio_intr_o;

  logic [31:0] rnd;
  int unsigned cycles;
  int          err_cnt;
  int          base_err;
  int          n_pass;
  int          n_fail;
  dat_t        mirror [RAM_WORDS];
  bit          valid  [RAM_WORDS];

  // pending comparisons for the compare process
  string name_q [$];
  dat_t  got_q  [$];
  dat_t  exp_q  [$];
  time   time_q [$];

  mini_mcu_top uut (
    .clk_i, .arst_n_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o, .wb_err_o,
    .gpio_i, .gpio_o, .gpio_oe_o, .gpio_intr_o
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected word after a write with byte selects
  function automatic dat_t merged_word(input dat_t old_w, input dat_t new_w, input sel_t sel);
    dat_t res;
    res = old_w;
    for (int b = 0; b < mcu_pkg::SEL_W; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic queue_check(input string name, input dat_t got, input dat_t exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
    time_q.push_back($time);
  endtask

  task automatic report_failure(input string msg);
    $display("%0t: %s", $time, msg);
    err_cnt++;
  endtask

  // one Wishbone classic cycle, waits for ack or err
  task automatic transfer(input logic we, input sel_t sel, input adr_t adr, input dat_t wdat,
                          output dat_t rdat, output logic ack, output logic err);
    int n;
    n = 0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do begin
      @(negedge clk_i);
      n++;
    end while (!wb_ack_o && !wb_err_o && n < RSP_LIMIT);
    ack      = wb_ack_o;
    err      = wb_err_o;
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!ack && !err) begin
      report_failure($sformatf("no response to the access at address %h", adr));
    end
    @(negedge clk_i);
    if (wb_ack_o || wb_err_o) begin
      report_failure($sformatf("more than one response to the access at address %h", adr));
    end
  endtask

  task automatic write_word(input adr_t adr, input sel_t sel, input dat_t wdat);
    dat_t rd;
    logic ack;
    logic err;
    transfer(1'b1, sel, adr, wdat, rd, ack, err);
    if (!ack || err) begin
      report_failure($sformatf("write to address %h was not acknowledged", adr));
    end
  endtask

  task automatic read_word(input adr_t adr, output dat_t rd);
    logic ack;
    logic err;
    transfer(1'b0, '1, adr, '0, rd, ack, err);
    if (!ack || err) begin
      report_failure($sformatf("read from address %h was not acknowledged", adr));
    end
  endtask

  task automatic end_test(input string name);
    @(posedge clk_i);
    @(negedge clk_i);
    if (err_cnt == base_err) begin
      $display("test %s: passed", name);
      n_pass++;
    end else begin
      $display("test %s: failed with %0d errors", name, err_cnt - base_err);
      n_fail++;
    end
    base_err = err_cnt;
  endtask

  // compares what the stimulus queued at the falling edge
  always @(posedge clk_i) begin : compare
    string nm;
    dat_t  got;
    dat_t  exp;
    time   t;
    while (name_q.size() != 0) begin
      nm  = name_q.pop_front();
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      t   = time_q.pop_front();
      if (got !== exp) begin
        $display("ERROR %0t %s: got %h expected %h", t, nm, got, exp);
        err_cnt++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, tests did not finish", cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    dat_t rd;
    dat_t wd;
    sel_t sel;
    logic ack;
    logic err;
    int   w;
    int   n;
    int   last_w;
    pin_t out_v;
    pin_t oe_v;
    pin_t in_v;
    pin_t mask;
    clk_i    = 1'b0;
    arst_n_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_sel_i = '0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    gpio_i   = '0;
    rnd      = 32'h82f9;
    cycles   = 0;
    err_cnt  = 0;
    base_err = 0;
    n_pass   = 0;
    n_fail   = 0;
    last_w   = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    @(negedge clk_i);
    queue_check("gpio_o", dat_t'(gpio_o), '0);
    queue_check("gpio_oe_o", dat_t'(gpio_oe_o), '0);
    queue_check("gpio_intr_o", dat_t'(gpio_intr_o), '0);
    queue_check("wb_ack_o", dat_t'(wb_ack_o), '0);
    queue_check("wb_err_o", dat_t'(wb_err_o), '0);
    end_test("reset state");

    for (int i = 0; i < RAM_OPS; i++) begin
      rnd = lcg_step(rnd);
      w   = int'((rnd >> 8) % RAM_WORDS);
      sel = rnd[27:24];
      // unwritten words get a full write first
      if (sel == '0 || !valid[w] || rnd[31]) begin
        sel = '1;
      end
      rnd = lcg_step(rnd);
      wd  = rnd;
      write_word(adr_t'(w * 4), sel, wd);
      mirror[w] = merged_word(mirror[w], wd, sel);
      valid[w]  = 1'b1;
      last_w    = w;
      read_word(adr_t'(w * 4), rd);
      queue_check("wb_dat_o", rd, mirror[w]);
    end
    end_test("ram write and read");

    // unmapped addresses that alias a written word in the low bits
    transfer(1'b1, '1, adr_t'(32'h0400 + last_w * 4), ~mirror[last_w], rd, ack, err);
    if (ack || !err) begin
      report_failure("write between RAM and GPIO did not end in an error");
    end
    transfer(1'b0, '1, adr_t'(32'h7ff0), '0, rd, ack, err);
    if (ack || !err) begin
      report_failure("read between RAM and GPIO did not end in an error");
    end
    transfer(1'b1, '1, adr_t'(32'h9000 + last_w * 4), ~mirror[last_w], rd, ack, err);
    if (ack || !err) begin
      report_failure("write above the GPIO window did not end in an error");
    end
    read_word(adr_t'(last_w * 4), rd);
    queue_check("wb_dat_o", rd, mirror[last_w]);
    end_test("unmapped address");

    rnd   = lcg_step(rnd);
    out_v = rnd[15:8];
    oe_v  = rnd[23:16];
    write_word(mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_OUT_OFS, 4'h1, dat_t'(out_v));
    queue_check("gpio_o", dat_t'(gpio_o), dat_t'(out_v));
    write_word(mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_OE_OFS, 4'h1, dat_t'(oe_v));
    queue_check("gpio_oe_o", dat_t'(gpio_oe_o), dat_t'(oe_v));
    read_word(mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_OUT_OFS, rd);
    queue_check("wb_dat_o", rd, dat_t'(out_v));
    read_word(mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_OE_OFS, rd);
    queue_check("wb_dat_o", rd, dat_t'(oe_v));
    end_test("gpio drive");

    rnd  = lcg_step(rnd);
    in_v = rnd[23:16];
    @(negedge clk_i);
    gpio_i = in_v;
    repeat (3) @(negedge clk_i);
    read_word(mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_IN_OFS, rd);
    queue_check("wb_dat_o", rd, dat_t'(in_v));
    end_test("gpio input");

    rnd  = lcg_step(rnd);
    // at least one pin enabled and at least one disabled
    mask = (rnd[15:8] | 8'h01) & 8'h7f;
    @(negedge clk_i);
    gpio_i = '0;
    repeat (4) @(negedge clk_i);
    write_word(mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_IEN_OFS, 4'h1, dat_t'(mask));
    write_word(mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_IST_OFS, 4'h1, dat_t'(8'hff));
    gpio_i = '1;
    n = 0;
    while (n < 4 && gpio_intr_o != mask) begin
      @(negedge clk_i);
      n++;
    end
    if (gpio_intr_o != mask) begin
      report_failure("enabled interrupts did not rise within 4 cycles");
    end
    queue_check("gpio_intr_o", dat_t'(gpio_intr_o), dat_t'(mask));
    write_word(mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_IST_OFS, 4'h1, dat_t'(mask));
    queue_check("gpio_intr_o", dat_t'(gpio_intr_o), '0);
    end_test("gpio interrupt");

    $display("%0d tests passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/mini_mcu_sva.sv ====
/*
 * Wishbone response assertions, bound to mini_mcu_top
 */
`timescale 1ns/1ps
`default_nettype none

module mini_mcu_sva (
  input wire logic clk_i,
  input wire logic arst_n_i,
  input wire logic cyc_i,
  input wire logic stb_i,
  input wire logic ack_i,
  input wire logic err_i
);

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ack_i && err_i)) else $error("ack and err high in the same cycle");

  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |=> !ack_i) else $error("ack high for two cycles");

  a_err_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    err_i |=> !err_i) else $error("err high for two cycles");

  // response one cycle after a sampled request
  a_rsp_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ack_i || err_i) |-> $past(cyc_i && stb_i)) else $error("response without a request");

endmodule

bind mini_mcu_top mini_mcu_sva u_sva (
  .clk_i   (clk_i),
  .arst_n_i(arst_n_i),
  .cyc_i   (wb_cyc_i),
  .stb_i   (wb_stb_i),
  .ack_i   (wb_ack_o),
  .err_i   (wb_err_o)
);

`default_nettype wire

// ==== src/mini_mcu_top.sv ====
/*
 * MCU fabric top: Wishbone port, decoder, RAM banks, always-on GPIO, response merge
 */
`timescale 1ns/1ps
`default_nettype none

module mini_mcu_top #(
  parameter int unsigned NUM_BANKS  = mcu_pkg::DEF_NUM_BANKS,
  parameter int unsigned BANK_WORDS = mcu_pkg::DEF_BANK_WORDS
) (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,

  // data port, Wishbone classic slave
  input  wire logic                        wb_cyc_i,
  input  wire logic                        wb_stb_i,
  input  wire logic                        wb_we_i,
  input  wire logic [mcu_pkg::SEL_W-1:0]   wb_sel_i,
  input  wire logic [mcu_pkg::ADDR_W-1:0]  wb_adr_i,
  input  wire logic [mcu_pkg::DATA_W-1:0]  wb_dat_i,
  output      logic [mcu_pkg::DATA_W-1:0]  wb_dat_o,
  output      logic                        wb_ack_o,
  output      logic                        wb_err_o,

  // always-on GPIO pins
  input  wire logic [mcu_pkg::GPIO_W-1:0]  gpio_i,
  output      logic [mcu_pkg::GPIO_W-1:0]  gpio_o,
  output      logic [mcu_pkg::GPIO_W-1:0]  gpio_oe_o,
  output      logic [mcu_pkg::GPIO_W-1:0]  gpio_intr_o
);

  wb_if bank_bus [NUM_BANKS] ();
  wb_if gpio_bus ();

  logic dec_err;

  addr_decoder #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) u_addr_decoder (
    .clk_i,
    .arst_n_i,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_sel_i,
    .wb_adr_i,
    .wb_dat_i,
    .bank_bus(bank_bus),
    .gpio_bus(gpio_bus),
    .err_o   (dec_err)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_ram
    ram_bank #(
      .BANK_WORDS(BANK_WORDS)
    ) u_ram_bank (
      .clk_i,
      .arst_n_i,
      .bus(bank_bus[i])
    );
  end

  gpio_ao u_gpio_ao (
    .clk_i,
    .arst_n_i,
    .bus(gpio_bus),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_intr_o
  );

  rsp_collector #(
    .NUM_BANKS(NUM_BANKS)
  ) u_rsp_collector (
    .bank_bus (bank_bus),
    .gpio_bus (gpio_bus),
    .dec_err_i(dec_err),
    .wb_dat_o,
    .wb_ack_o,
    .wb_err_o
  );

endmodule

`default_nettype wire

// ==== src/gpio_ao.sv ====
/*
 * always-on GPIO: out/oe/ien registers, input sync, edge interrupt status
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_ao (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  wb_if.slave                              bus,
  input  wire logic [mcu_pkg::GPIO_W-1:0]  gpio_i,
  output      logic [mcu_pkg::GPIO_W-1:0]  gpio_o,
  output      logic [mcu_pkg::GPIO_W-1:0]  gpio_oe_o,
  output      logic [mcu_pkg::GPIO_W-1:0]  gpio_intr_o
);

  logic                       req;
  logic                       wr;
  logic                       ack_q;
  logic [mcu_pkg::GPIO_W-1:0] out_q;
  logic [mcu_pkg::GPIO_W-1:0] oe_q;
  logic [mcu_pkg::GPIO_W-1:0] ien_q;
  logic [mcu_pkg::GPIO_W-1:0] ist_q;
  logic [mcu_pkg::GPIO_W-1:0] sync1_q;
  logic [mcu_pkg::GPIO_W-1:0] sync2_q;
  logic [mcu_pkg::GPIO_W-1:0] prev_q;
  logic [mcu_pkg::GPIO_W-1:0] rise;
  logic [mcu_pkg::GPIO_W-1:0] clr;
  logic [mcu_pkg::DATA_W-1:0] rdata_d;
  logic [mcu_pkg::DATA_W-1:0] rdata_q;

  assign req  = bus.cyc & bus.stb & ~ack_q;
  // pins live in byte lane 0
  assign wr   = req & bus.we & bus.sel[0];
  assign rise = sync2_q & ~prev_q;
  assign clr  = (wr && bus.adr == mcu_pkg::GPIO_IST_OFS) ?
                bus.dat_w[mcu_pkg::GPIO_W-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q   <= 1'b0;
      out_q   <= '0;
      oe_q    <= '0;
      ien_q   <= '0;
      ist_q   <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      ack_q   <= req;
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr && bus.adr == mcu_pkg::GPIO_OUT_OFS) begin
        out_q <= bus.dat_w[mcu_pkg::GPIO_W-1:0];
      end
      if (wr && bus.adr == mcu_pkg::GPIO_OE_OFS) begin
        oe_q <= bus.dat_w[mcu_pkg::GPIO_W-1:0];
      end
      if (wr && bus.adr == mcu_pkg::GPIO_IEN_OFS) begin
        ien_q <= bus.dat_w[mcu_pkg::GPIO_W-1:0];
      end
      // a new edge wins over a clear in the same cycle
      ist_q <= (ist_q & ~clr) | (rise & ien_q);
    end
  end

  always_comb begin
    rdata_d = '0;
    case (bus.adr)
      mcu_pkg::GPIO_OUT_OFS: rdata_d[mcu_pkg::GPIO_W-1:0] = out_q;
      mcu_pkg::GPIO_OE_OFS:  rdata_d[mcu_pkg::GPIO_W-1:0] = oe_q;
      mcu_pkg::GPIO_IN_OFS:  rdata_d[mcu_pkg::GPIO_W-1:0] = sync2_q;
      mcu_pkg::GPIO_IEN_OFS: rdata_d[mcu_pkg::GPIO_W-1:0] = ien_q;
      mcu_pkg::GPIO_IST_OFS: rdata_d[mcu_pkg::GPIO_W-1:0] = ist_q;
      default:               rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req && !bus.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.dat_r   = rdata_q;
  assign bus.ack     = ack_q;
  assign bus.err     = 1'b0;

  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  assign gpio_intr_o = ist_q;

endmodule

`default_nettype wire

// ==== src/rsp_collector.sv ====
/*
 * response merge of RAM banks, GPIO and decoder error onto the port
 */
`timescale 1ns/1ps
`default_nettype none

module rsp_collector #(
  parameter int unsigned NUM_BANKS = mcu_pkg::DEF_NUM_BANKS
) (
  wb_if.slave                              bank_bus [NUM_BANKS],
  wb_if.slave                              gpio_bus,
  input  wire logic                        dec_err_i,
  output      logic [mcu_pkg::DATA_W-1:0]  wb_dat_o,
  output      logic                        wb_ack_o,
  output      logic                        wb_err_o
);

  logic [NUM_BANKS-1:0]       bank_ack;
  logic [NUM_BANKS-1:0]       bank_err;
  logic [mcu_pkg::DATA_W-1:0] bank_dat [NUM_BANKS];

  // only the acking slave contributes data
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    assign bank_ack[i] = bank_bus[i].ack;
    assign bank_err[i] = bank_bus[i].err;
    assign bank_dat[i] = bank_bus[i].ack ? bank_bus[i].dat_r : '0;
  end

  always_comb begin
    wb_dat_o = gpio_bus.ack ? gpio_bus.dat_r : '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      wb_dat_o = wb_dat_o | bank_dat[i];
    end
  end

  assign wb_ack_o = (|bank_ack) | gpio_bus.ack;
  assign wb_err_o = dec_err_i | (|bank_err) | gpio_bus.err;

endmodule

`default_nettype wire

// ==== src/ram_bank.sv ====
/*
 * single-port RAM bank with byte selects behind a Wishbone slave
 */
`timescale 1ns/1ps
`default_nettype none

module ram_bank #(
  parameter int unsigned BANK_WORDS = mcu_pkg::DEF_BANK_WORDS
) (
  input wire logic clk_i,
  input wire logic arst_n_i,
  wb_if.slave      bus
);

  localparam int unsigned IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  logic [mcu_pkg::DATA_W-1:0] mem_q [BANK_WORDS];
  logic [mcu_pkg::DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]           idx;
  logic                       req;
  logic                       ack_q;

  // word index from the low address bits
  assign idx = bus.adr[2 +: IDX_W];

  // new request only, not the cycle that is being acked
  assign req = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && bus.we) begin
      for (int b = 0; b < mcu_pkg::SEL_W; b++) begin
        if (bus.sel[b]) begin
          mem_q[idx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
        end
      end
    end
    if (req && !bus.we) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign bus.dat_r = rdata_q;
  assign bus.ack   = ack_q;
  // every in-range word exists
  assign bus.err   = 1'b0;

endmodule

`default_nettype wire

// ==== src/addr_decoder.sv ====
/*
 * address decoder: RAM bank and GPIO strobes, registered error for unmapped accesses
 */
`timescale 1ns/1ps
`default_nettype none

module addr_decoder #(
  parameter int unsigned NUM_BANKS  = mcu_pkg::DEF_NUM_BANKS,
  parameter int unsigned BANK_WORDS = mcu_pkg::DEF_BANK_WORDS
) (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic                        wb_cyc_i,
  input  wire logic                        wb_stb_i,
  input  wire logic                        wb_we_i,
  input  wire logic [mcu_pkg::SEL_W-1:0]   wb_sel_i,
  input  wire logic [mcu_pkg::ADDR_W-1:0]  wb_adr_i,
  input  wire logic [mcu_pkg::DATA_W-1:0]  wb_dat_i,
  wb_if.master                             bank_bus [NUM_BANKS],
  wb_if.master                             gpio_bus,
  output      logic                        err_o
);

  typedef logic [mcu_pkg::ADDR_W-1:0] adr_t;

  localparam adr_t RAM_BYTES = adr_t'(NUM_BANKS * BANK_WORDS * 4);
  localparam adr_t GPIO_SPAN = mcu_pkg::GPIO_IST_OFS + adr_t'(4);

  logic        req;
  adr_t        ram_off;
  adr_t        gpio_off;
  logic        ram_hit;
  logic        gpio_hit;
  logic [31:0] bank_num;
  logic        err_q;

  assign req = wb_cyc_i & wb_stb_i;

  // slaves see addresses relative to their own window
  assign ram_off  = wb_adr_i - mcu_pkg::RAM_BASE;
  assign gpio_off = wb_adr_i - mcu_pkg::GPIO_BASE;
  assign ram_hit  = ram_off < RAM_BYTES;
  assign gpio_hit = gpio_off < GPIO_SPAN;

  // contiguous banks
  assign bank_num = 32'(ram_off[mcu_pkg::ADDR_W-1:2]) / BANK_WORDS;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    assign bank_bus[i].cyc   = wb_cyc_i;
    assign bank_bus[i].stb   = req & ram_hit & (bank_num == i);
    assign bank_bus[i].we    = wb_we_i;
    assign bank_bus[i].sel   = wb_sel_i;
    assign bank_bus[i].adr   = ram_off;
    assign bank_bus[i].dat_w = wb_dat_i;
  end

  assign gpio_bus.cyc   = wb_cyc_i;
  assign gpio_bus.stb   = req & gpio_hit;
  assign gpio_bus.we    = wb_we_i;
  assign gpio_bus.sel   = wb_sel_i;
  assign gpio_bus.adr   = gpio_off;
  assign gpio_bus.dat_w = wb_dat_i;

  // one error pulse per unmapped request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req & ~ram_hit & ~gpio_hit & ~err_q;
    end
  end

  assign err_o = err_q;

endmodule

`default_nettype wire

// ==== src/wb_if.sv ====
/*
 * Wishbone classic bus bundle with master and slave modports
 */
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

  // request
  logic                        cyc;
  logic                        stb;
  logic                        we;
  logic [mcu_pkg::SEL_W-1:0]   sel;
  logic [mcu_pkg::ADDR_W-1:0]  adr;
  logic [mcu_pkg::DATA_W-1:0]  dat_w;

  // response
  logic [mcu_pkg::DATA_W-1:0]  dat_r;
  logic                        ack;
  logic                        err;

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

// ==== src/mcu_pkg.sv ====
/*
 * bus widths, address map and GPIO register offsets for the MCU fabric
 */
`default_nettype none

package mcu_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned SEL_W  = DATA_W / 8;

  // always-on GPIO pins, register map is laid out for 8
  localparam int unsigned GPIO_W = 8;

  // address map
  localparam logic [ADDR_W-1:0] RAM_BASE  = 16'h0000;
  localparam logic [ADDR_W-1:0] GPIO_BASE = 16'h8000;

  // GPIO register offsets inside the GPIO window
  localparam logic [ADDR_W-1:0] GPIO_OUT_OFS = 16'h0000;
  localparam logic [ADDR_W-1:0] GPIO_OE_OFS  = 16'h0004;
  // read only, synchronised pin state
  localparam logic [ADDR_W-1:0] GPIO_IN_OFS  = 16'h0008;
  localparam logic [ADDR_W-1:0] GPIO_IEN_OFS = 16'h000C;
  // write 1 to clear
  localparam logic [ADDR_W-1:0] GPIO_IST_OFS = 16'h0010;

  // default memory geometry
  localparam int unsigned DEF_NUM_BANKS  = 4;
  localparam int unsigned DEF_BANK_WORDS = 64;

endpackage

`default_nettype wire
